// File: logic/bp_pkg.sv
// Branch predictor types shared by the fetch lookup path and the execute resolution path
`default_nettype none

package bp_pkg;

    typedef enum logic [1:0] {
        KIND_BRANCH = 2'd0, // conditional branch, direction from the pattern table
        KIND_JAL    = 2'd1,
        KIND_JALR   = 2'd2
    } bp_kind_e;

    // answer returned to fetch in the same cycle as the pc
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
        logic [7:0]  pht_index; // wide enough for any history length
    } bp_lookup_t;

    typedef struct packed {
        logic [31:0] pc;
        bp_kind_e    kind;
        logic        taken;
        logic [31:0] target;
        logic        pred_taken;  // what fetch was told for this pc
        logic [31:0] pred_target;
        logic [7:0]  pht_index;
    } bp_resolve_t;

    typedef struct packed {
        logic        we;
        logic [31:0] pc;
        logic [31:0] target;
        bp_kind_e    kind;
    } bp_btb_wr_t;

    typedef struct packed {
        logic       en;
        logic       inc;   // count up when the branch was taken
        logic [7:0] index;
    } bp_pht_upd_t;

endpackage

`default_nettype wire

// File: logic/apb_pkg.sv
// APB signal bundles and the register map of the predictor control port
`default_nettype none

package apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    typedef enum logic [3:0] {
        REG_CTRL     = 4'h0, // bit 0 enable, bit 1 flush (write only)
        REG_RESOLVED = 4'h4,
        REG_MISPRED  = 4'h8
    } bp_reg_e;

endpackage

`default_nettype wire

// File: logic/bp_resolve.sv
// Turns execute resolution records into BTB writes, counter updates, history shifts and stats
`default_nettype none

module bp_resolve #(
    parameter int BTB_ENTRIES = 32,
    parameter int GHR_BITS    = 5
) (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire logic                res_valid_i,
    input  wire bp_pkg::bp_resolve_t res_i,
    output bp_pkg::bp_btb_wr_t       btb_wr_o,
    output bp_pkg::bp_pht_upd_t      pht_upd_o,
    output logic                     ghr_shift_o,
    output logic                     ghr_taken_o,
    output logic                     resolved_o,
    output logic                     mispred_o
);
    import bp_pkg::*;

    logic is_branch;
    logic target_wrong;
    logic last_jal_q;

    if (BTB_ENTRIES < 4 || BTB_ENTRIES > 256
            || (BTB_ENTRIES & (BTB_ENTRIES - 1)) != 0) begin : g_bad_btb
        $error("BTB_ENTRIES must be a power of two from 4 to 256");
    end
    if (GHR_BITS < 2 || GHR_BITS > 8) begin : g_bad_ghr
        $error("GHR_BITS must be from 2 to 8");
    end

    assign is_branch    = res_i.kind == KIND_BRANCH;
    assign target_wrong = res_i.taken && res_i.pred_taken && (res_i.pred_target != res_i.target);

    // only taken transfers are worth a BTB entry
    assign btb_wr_o.we     = res_valid_i && res_i.taken;
    assign btb_wr_o.pc     = res_i.pc;
    assign btb_wr_o.target = res_i.target;
    assign btb_wr_o.kind   = res_i.kind;

    assign pht_upd_o.en    = res_valid_i && is_branch;
    assign pht_upd_o.inc   = res_i.taken;
    assign pht_upd_o.index = 8'(res_i.pht_index[GHR_BITS-1:0]); // upper bits are never produced

    assign ghr_shift_o = res_valid_i && is_branch;
    assign ghr_taken_o = res_i.taken;

    assign resolved_o = res_valid_i;
    assign mispred_o  = res_valid_i && ((res_i.pred_taken != res_i.taken) || target_wrong);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_jal_q <= 1'b0;
        end else begin
            last_jal_q <= res_valid_i && res_i.kind == KIND_JAL;
        end
    end

    // a jal is unconditional so execute must never hand one back as not taken
    a_jal_taken: assert property (@(posedge clk) disable iff (!rst_n_i)
        last_jal_q |-> $past(res_i.taken));

endmodule

`default_nettype wire

// File: logic/bp_btb.sv
// Direct-mapped branch target buffer with combinational lookup and single write port
`default_nettype none

module bp_btb #(
    parameter int BTB_ENTRIES = 32
) (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               flush_i,
    input  wire logic [31:0]        lookup_pc_i,
    input  wire bp_pkg::bp_btb_wr_t wr_i,
    output logic                    hit_o,
    output bp_pkg::bp_kind_e        kind_o,
    output logic [31:0]             target_o
);
    import bp_pkg::*;

    localparam int IDX_BITS = $clog2(BTB_ENTRIES);
    localparam int TAG_BITS = 30 - IDX_BITS; // pc bits above the index

    logic [TAG_BITS-1:0]    tag_q    [BTB_ENTRIES];
    logic [31:0]            target_q [BTB_ENTRIES];
    bp_kind_e               kind_q   [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid_q;

    logic [IDX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0] rd_tag;
    logic [IDX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0] wr_tag;

    assign rd_idx = lookup_pc_i[IDX_BITS+1:2];
    assign rd_tag = lookup_pc_i[31:IDX_BITS+2];
    assign wr_idx = wr_i.pc[IDX_BITS+1:2];
    assign wr_tag = wr_i.pc[31:IDX_BITS+2];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign kind_o   = kind_q[rd_idx];
    assign target_o = target_q[rd_idx]; // meaningful only with hit_o

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0; // flush wins over a resolution in the same cycle
        end else if (wr_i.we) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.we && !flush_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_i.target;
            kind_q[wr_idx]   <= wr_i.kind;
        end
    end

endmodule

`default_nettype wire

// File: logic/bp_gshare.sv
// Gshare direction predictor: global history register and table of 2-bit saturating counters
`default_nettype none

module bp_gshare #(
    parameter int GHR_BITS = 5
) (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire logic                flush_i,
    input  wire logic [31:0]         lookup_pc_i,
    input  wire bp_pkg::bp_pht_upd_t upd_i,
    input  wire logic                ghr_shift_i,
    input  wire logic                ghr_taken_i,
    output logic                     predict_taken_o,
    output logic [7:0]               index_o
);

    localparam int PHT_ENTRIES = 1 << GHR_BITS;

    logic [GHR_BITS-1:0] ghr_q;
    logic [1:0]          pht_q [PHT_ENTRIES];
    logic [GHR_BITS-1:0] rd_idx;
    logic [GHR_BITS-1:0] upd_idx;

    function automatic logic [1:0] next_count(input logic [1:0] cnt, input logic inc);
        if (inc) begin
            return (cnt == 2'b11) ? cnt : cnt + 2'b01;
        end
        return (cnt == 2'b00) ? cnt : cnt - 2'b01;
    endfunction

    assign rd_idx          = lookup_pc_i[GHR_BITS+1:2] ^ ghr_q;
    assign upd_idx         = upd_i.index[GHR_BITS-1:0];
    assign predict_taken_o = pht_q[rd_idx][1]; // upper bit of the counter is the direction
    assign index_o         = 8'(rd_idx);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ghr_q <= '0;
        end else if (flush_i) begin
            ghr_q <= '0;
        end else if (ghr_shift_i) begin
            ghr_q <= {ghr_q[GHR_BITS-2:0], ghr_taken_i}; // newest outcome at bit 0
        end
    end

    // counters start weakly not taken after reset and after a flush
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= 2'b01;
            end
        end else if (flush_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= 2'b01;
            end
        end else if (upd_i.en) begin
            pht_q[upd_idx] <= next_count(pht_q[upd_idx], upd_i.inc);
        end
    end

endmodule

`default_nettype wire

// File: logic/bp_apb_regs.sv
// APB control port: enable bit, flush pulse and saturating resolution and mispredict counters
`default_nettype none

module bp_apb_regs (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire apb_pkg::apb_req_t apb_i,
    output apb_pkg::apb_rsp_t      apb_o,
    input  wire logic              resolved_i,
    input  wire logic              mispred_i,
    output logic                   enable_o,
    output logic                   flush_o
);
    import apb_pkg::*;

    logic        enable_q;
    logic [31:0] resolved_q;
    logic [31:0] mispred_q;
    logic        access;
    logic        ctrl_wr;
    logic        addr_ok;
    logic [31:0] rdata;

    function automatic logic [31:0] sat_inc(input logic [31:0] v);
        return (v == '1) ? v : v + 32'd1;
    endfunction

    assign access  = apb_i.psel && apb_i.penable; // zero wait states, every access phase completes
    assign ctrl_wr = access && apb_i.pwrite && bp_reg_e'(apb_i.paddr) == REG_CTRL;

    always_comb begin
        rdata   = '0;
        addr_ok = 1'b1;
        case (bp_reg_e'(apb_i.paddr))
            REG_CTRL:     rdata = {31'b0, enable_q}; // flush bit always reads back 0
            REG_RESOLVED: rdata = resolved_q;
            REG_MISPRED:  rdata = mispred_q;
            default:      addr_ok = 1'b0;
        endcase
    end

    assign apb_o.pready  = 1'b1;
    assign apb_o.pslverr = access && !addr_ok;
    assign apb_o.prdata  = (access && !apb_i.pwrite) ? rdata : '0;

    assign enable_o = enable_q;
    assign flush_o  = ctrl_wr && apb_i.pwdata[1]; // lands at the same edge as the write

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q   <= 1'b1;
            resolved_q <= '0;
            mispred_q  <= '0;
        end else begin
            if (ctrl_wr) begin
                enable_q <= apb_i.pwdata[0];
            end
            if (flush_o) begin
                resolved_q <= '0;
                mispred_q  <= '0;
            end else begin
                if (resolved_i) begin
                    resolved_q <= sat_inc(resolved_q);
                end
                if (mispred_i) begin
                    mispred_q <= sat_inc(mispred_q);
                end
            end
        end
    end

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n_i)
        apb_i.penable |-> apb_i.psel);

endmodule

`default_nettype wire

// File: logic/bp_top.sv
// Branch predictor top level joining fetch lookup, execute resolution and the APB control port
`default_nettype none

module bp_top #(
    parameter int BTB_ENTRIES = 32,
    parameter int GHR_BITS    = 5
) (
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire logic [31:0]         fetch_pc_i,
    output bp_pkg::bp_lookup_t       lookup_o,
    input  wire logic                res_valid_i,
    input  wire bp_pkg::bp_resolve_t res_i,
    input  wire apb_pkg::apb_req_t   apb_i,
    output apb_pkg::apb_rsp_t        apb_o
);
    import bp_pkg::*;

    bp_btb_wr_t  btb_wr;
    bp_pht_upd_t pht_upd;
    logic        ghr_shift;
    logic        ghr_taken;
    logic        resolved;
    logic        mispred;
    logic        enable;
    logic        flush;
    logic        btb_hit;
    bp_kind_e    btb_kind;
    logic [31:0] btb_target;
    logic        pht_taken;
    logic [7:0]  pht_index;
    logic        dir_taken;

    bp_resolve #(
        .BTB_ENTRIES(BTB_ENTRIES),
        .GHR_BITS   (GHR_BITS)
    ) u_resolve (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .res_valid_i(res_valid_i),
        .res_i      (res_i),
        .btb_wr_o   (btb_wr),
        .pht_upd_o  (pht_upd),
        .ghr_shift_o(ghr_shift),
        .ghr_taken_o(ghr_taken),
        .resolved_o (resolved),
        .mispred_o  (mispred)
    );

    bp_btb #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) u_btb (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush),
        .lookup_pc_i(fetch_pc_i),
        .wr_i       (btb_wr),
        .hit_o      (btb_hit),
        .kind_o     (btb_kind),
        .target_o   (btb_target)
    );

    bp_gshare #(
        .GHR_BITS(GHR_BITS)
    ) u_gshare (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush),
        .lookup_pc_i    (fetch_pc_i),
        .upd_i          (pht_upd),
        .ghr_shift_i    (ghr_shift),
        .ghr_taken_i    (ghr_taken),
        .predict_taken_o(pht_taken),
        .index_o        (pht_index)
    );

    bp_apb_regs u_apb_regs (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .apb_i     (apb_i),
        .apb_o     (apb_o),
        .resolved_i(resolved),
        .mispred_i (mispred),
        .enable_o  (enable),
        .flush_o   (flush)
    );

    // jumps are always taken, branches follow their counter
    assign dir_taken = (btb_kind == KIND_JAL) || (btb_kind == KIND_JALR)
                    || (btb_kind == KIND_BRANCH && pht_taken);

    assign lookup_o.taken     = enable && btb_hit && dir_taken;
    assign lookup_o.target    = btb_hit ? btb_target : 32'b0;
    assign lookup_o.pht_index = pht_index;

endmodule

`default_nettype wire

// File: tests/bp_model.svh
// Reference model of BTB, pattern table, history and counters, included in the testbench body
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

logic [31:0]         m_btb_pc     [BTB_ENTRIES]; // full pc, same slot plus same pc means same tag
logic [31:0]         m_btb_target [BTB_ENTRIES];
bp_kind_e            m_btb_kind   [BTB_ENTRIES];
logic                m_btb_valid  [BTB_ENTRIES];
logic [1:0]          m_pht        [1 << GHR_BITS];
logic [GHR_BITS-1:0] m_ghr;
logic                m_enable;
logic [31:0]         m_resolved;
logic [31:0]         m_mispred;

function automatic int btb_slot(input logic [31:0] pc);
    return int'(pc[31:2]) % BTB_ENTRIES;
endfunction

function automatic void model_flush();
    for (int i = 0; i < BTB_ENTRIES; i++) begin
        m_btb_valid[i] = 1'b0;
    end
    for (int i = 0; i < (1 << GHR_BITS); i++) begin
        m_pht[i] = 2'b01; // weakly not taken
    end
    m_ghr      = '0;
    m_resolved = '0;
    m_mispred  = '0;
endfunction

function automatic void model_reset();
    model_flush();
    m_enable = 1'b1;
endfunction

function automatic bp_lookup_t model_lookup(input logic [31:0] pc);
    bp_lookup_t          ans;
    int                  s;
    logic                hit;
    logic [GHR_BITS-1:0] idx;
    s   = btb_slot(pc);
    hit = m_btb_valid[s] && (m_btb_pc[s][31:2] == pc[31:2]);
    idx = pc[GHR_BITS+1:2] ^ m_ghr;
    ans.pht_index = 8'(idx);
    ans.target    = hit ? m_btb_target[s] : 32'h0;
    ans.taken     = m_enable && hit && (m_btb_kind[s] != KIND_BRANCH || m_pht[idx][1]);
    return ans;
endfunction

function automatic void model_resolve(input bp_resolve_t r);
    int                  s;
    logic [GHR_BITS-1:0] idx;
    s   = btb_slot(r.pc);
    idx = r.pht_index[GHR_BITS-1:0];
    if (r.taken) begin
        m_btb_valid[s]  = 1'b1;
        m_btb_pc[s]     = r.pc;
        m_btb_target[s] = r.target;
        m_btb_kind[s]   = r.kind;
    end
    if (r.kind == KIND_BRANCH) begin
        if (r.taken && m_pht[idx] != 2'b11) begin
            m_pht[idx] = m_pht[idx] + 2'b01;
        end else if (!r.taken && m_pht[idx] != 2'b00) begin
            m_pht[idx] = m_pht[idx] - 2'b01;
        end
        m_ghr = {m_ghr[GHR_BITS-2:0], r.taken}; // newest outcome enters at bit 0
    end
    if (m_resolved != '1) begin
        m_resolved = m_resolved + 32'd1;
    end
    if (r.pred_taken != r.taken || (r.taken && r.pred_taken && r.pred_target != r.target)) begin
        if (m_mispred != '1) begin
            m_mispred = m_mispred + 32'd1;
        end
    end
endfunction

`endif

// File: tests/bp_tb.sv
// Testbench for the branch predictor top level, random resolutions checked against a model
`default_nettype none

module bp_tb;
    import bp_pkg::*;
    import apb_pkg::*;

    localparam int BTB_ENTRIES = 32;
    localparam int GHR_BITS    = 5;
    localparam int TEST_CYCLES = 5 + 25 + 8 + 600 + 6 + 166 + 71; // reset, then tests 1 to 6
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] fetch_pc;
    bp_lookup_t  lookup;
    logic        res_valid;
    bp_resolve_t res;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    logic [15:0] lfsr_q;
    logic [31:0] pool [16];
    int          cycles = 0;
    int          errors;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;

    `include "bp_model.svh"

    bp_top #(
        .BTB_ENTRIES(BTB_ENTRIES),
        .GHR_BITS   (GHR_BITS)
    ) i_dut (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch_pc_i (fetch_pc),
        .lookup_o   (lookup),
        .res_valid_i(res_valid),
        .res_i      (res),
        .apb_i      (apb_req),
        .apb_o      (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic rand_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fetch(input logic [31:0] pc, output bp_lookup_t ans);
        bp_lookup_t exp;
        next_cycle();
        fetch_pc  = pc;
        res_valid = 1'b0;
        #1; // let the combinational lookup settle
        ans = lookup;
        exp = model_lookup(pc);
        check_eq(32'(ans.taken), 32'(exp.taken), $sformatf("lookup taken, pc %h", pc));
        check_eq(ans.target, exp.target, $sformatf("lookup target, pc %h", pc));
        check_eq(32'(ans.pht_index), 32'(exp.pht_index), $sformatf("lookup index, pc %h", pc));
    endtask

    task automatic resolve(input bp_resolve_t r);
        next_cycle();
        res       = r;
        res_valid = 1'b1;
        model_resolve(r); // commits at the same edge as the DUT
    endtask

    function automatic bp_resolve_t make_record(input logic [31:0] pc, input bp_kind_e kind,
            input logic taken, input logic [31:0] target, input bp_lookup_t ans);
        bp_resolve_t r;
        r.pc          = pc;
        r.kind        = kind;
        r.taken       = taken;
        r.target      = target;
        r.pred_taken  = ans.taken;
        r.pred_target = ans.target;
        r.pht_index   = ans.pht_index;
        return r;
    endfunction

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        next_cycle();
        res_valid      = 1'b0;
        apb_req.psel   = 1'b1;
        apb_req.pwrite = 1'b1;
        apb_req.paddr  = addr;
        apb_req.pwdata = data;
        next_cycle();
        apb_req.penable = 1'b1;
        #1;
        while (!apb_rsp.pready) begin
            next_cycle();
        end
        if (addr == REG_CTRL) begin
            m_enable = data[0];
            if (data[1]) begin
                model_flush();
            end
        end
        next_cycle();
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        next_cycle();
        res_valid      = 1'b0;
        apb_req.psel   = 1'b1;
        apb_req.pwrite = 1'b0;
        apb_req.paddr  = addr;
        next_cycle();
        apb_req.penable = 1'b1;
        #1;
        while (!apb_rsp.pready) begin
            next_cycle();
        end
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        next_cycle();
        apb_req = '0;
    endtask

    task automatic random_step();
        logic [3:0]  sel;
        logic [1:0]  k;
        logic [31:0] pc;
        bp_kind_e    kind;
        logic        taken;
        logic [31:0] target;
        bp_lookup_t  ans;
        sel = 4'(rand_bits(4));
        pc  = pool[sel];
        k   = 2'(rand_bits(2));
        case (k)
            2'd1:    kind = KIND_JAL;
            2'd2:    kind = KIND_JALR;
            default: kind = KIND_BRANCH;
        endcase
        // half the pool leans taken, half leans not taken, so counters saturate both ways
        if (kind == KIND_BRANCH) begin
            taken = pc[4] ? (rand_bit() | rand_bit()) : (rand_bit() & rand_bit());
        end else begin
            taken = 1'b1;
        end
        target = rand_bit() ? pc + 32'h100 : (rand_bits(16) << 2);
        fetch(pc, ans);
        if (!m_enable) begin
            check_eq(32'(ans.taken), 32'd0, "lookup taken while disabled");
        end
        resolve(make_record(pc, kind, taken, target, ans));
    endtask

    initial begin
        bp_lookup_t  ans;
        logic [31:0] data;
        logic        err;
        rst_n_i      = 1'b0;
        fetch_pc     = '0;
        res_valid    = 1'b0;
        res          = '0;
        apb_req      = '0;
        lfsr_q       = 16'd65373;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        // pool[i + 8] shares a BTB slot with pool[i] under another tag
        for (int i = 0; i < 8; i++) begin
            pool[i]     = 32'h0000_1000 + 32'(i) * 4;
            pool[i + 8] = 32'h0000_2000 + 32'(i) * 4;
        end
        model_reset();
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        for (int i = 0; i < 16; i++) begin
            fetch(pool[i], ans);
            check_eq(32'(ans.taken), 32'd0, "taken after reset");
            check_eq(ans.target, 32'd0, "target after reset");
        end
        apb_read(REG_CTRL, data, err);
        check_eq(data, 32'd1, "ctrl after reset");
        check_eq(32'(err), 32'd0, "pslverr on ctrl");
        apb_read(REG_RESOLVED, data, err);
        check_eq(data, 32'd0, "resolved count after reset");
        apb_read(REG_MISPRED, data, err);
        check_eq(data, 32'd0, "mispredict count after reset");
        finish_test("reset state");

        fetch(pool[3], ans);
        resolve(make_record(pool[3], KIND_JAL, 1'b1, 32'h0000_4000, ans));
        fetch(pool[3], ans);
        check_eq(32'(ans.taken), 32'd1, "jal hit taken");
        check_eq(ans.target, 32'h0000_4000, "jal hit target");
        fetch(pool[11], ans);
        check_eq(32'(ans.taken), 32'd0, "aliased pc taken");
        check_eq(ans.target, 32'd0, "aliased pc target");
        fetch(pool[6], ans);
        resolve(make_record(pool[6], KIND_JALR, 1'b1, 32'h0000_5008, ans));
        fetch(pool[6], ans);
        check_eq(32'(ans.taken), 32'd1, "jalr hit taken");
        check_eq(ans.target, 32'h0000_5008, "jalr hit target");
        fetch(pool[14], ans);
        check_eq(32'(ans.taken), 32'd0, "aliased pc taken");
        finish_test("jump learning and aliasing");

        repeat (300) random_step();
        finish_test("random resolutions");

        apb_read(REG_RESOLVED, data, err);
        check_eq(data, m_resolved, "resolved count");
        check_eq(32'(err), 32'd0, "pslverr on resolved");
        apb_read(REG_MISPRED, data, err);
        check_eq(data, m_mispred, "mispredict count");
        finish_test("statistics counters");

        apb_write(REG_CTRL, 32'h0);
        repeat (40) random_step();
        apb_write(REG_CTRL, 32'h1);
        repeat (40) random_step();
        finish_test("enable control");

        apb_write(REG_CTRL, 32'h3);
        for (int i = 0; i < 16; i++) begin
            fetch(pool[i], ans);
            check_eq(32'(ans.taken), 32'd0, "taken after flush");
            check_eq(ans.target, 32'd0, "target after flush");
            check_eq(32'(ans.pht_index), 32'(pool[i][GHR_BITS+1:2]), "history after flush");
        end
        apb_read(REG_CTRL, data, err);
        check_eq(data, 32'd1, "ctrl after flush");
        apb_read(REG_RESOLVED, data, err);
        check_eq(data, 32'd0, "resolved count after flush");
        apb_read(REG_MISPRED, data, err);
        check_eq(data, 32'd0, "mispredict count after flush");
        apb_read(4'hC, data, err);
        check_eq(32'(err), 32'd1, "pslverr on unmapped address");
        repeat (20) random_step();
        finish_test("flush and bad address");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tests
logic/bp_pkg.sv
logic/apb_pkg.sv
logic/bp_resolve.sv
logic/bp_btb.sv
logic/bp_gshare.sv
logic/bp_apb_regs.sv
logic/bp_top.sv
tests/bp_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

obj_dir/Vbp_tb: vlog.f $(wildcard logic/*.sv tests/*.sv tests/*.svh)
	verilator --binary --timing --assert --top-module bp_tb -f vlog.f

test: obj_dir/Vbp_tb
	./obj_dir/Vbp_tb | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
